// ==== rtl/tlb_pkg.sv ====
// ==========================================================
// Sizes and types shared by every TLB block. The page size is
// fixed, so all page numbers count pages of that one size
// Entries carry a valid bit so a cleared entry never hits
// ==========================================================
`default_nettype none

package tlb_pkg;

    // ==========================================================
    // Geometry
    // ==========================================================

    // Page number widths after the page offset is removed
    localparam int tlb_va_page_bits = 20;
    localparam int tlb_pa_page_bits = 16;

    // Sets are direct mapped by the low bits of the virtual page
    localparam int tlb_num_sets = 64;
    localparam int tlb_num_ways = 4;
    localparam int tlb_idx_bits = $clog2(tlb_num_sets);
    localparam int tlb_tag_bits = tlb_va_page_bits - tlb_idx_bits;

    // Latency of the lookup path, from request edge to result
    localparam int tlb_lookup_stages = 4;

    // Idle cycles the fill path spends after each insert
    localparam int tlb_fill_bubble_cycles = 3;

    // ==========================================================
    // Types
    // ==========================================================

    typedef logic [tlb_idx_bits-1:0]         tlb_set_idx_t;
    typedef logic [tlb_tag_bits-1:0]         tlb_tag_t;
    typedef logic [tlb_pa_page_bits-1:0]     tlb_pa_page_t;
    typedef logic [$clog2(tlb_num_ways)-1:0] tlb_way_idx_t;
    typedef logic [tlb_num_ways-1:0]         tlb_way_vec_t;

    // One stored translation
    typedef struct packed
    {
        logic         valid;
        tlb_tag_t     tag;
        tlb_pa_page_t pa;
    } tlb_entry_t;

    // Tag in the high bits, set index in the low bits
    typedef struct packed
    {
        tlb_tag_t     tag;
        tlb_set_idx_t idx;
    } tlb_va_fields_t;

    // The same virtual page seen whole or split for the set lookup
    typedef union packed
    {
        logic [tlb_va_page_bits-1:0] page;
        tlb_va_fields_t              f;
    } tlb_va_page_u;

    typedef enum logic [2:0]
    {
        fill_idle,
        fill_req_way,
        fill_recv_way,
        fill_insert,
        fill_bubble
    } tlb_fill_state_t;

endpackage

`default_nettype wire

// ==== rtl/tlb_way_ram.sv ====
// ==========================================================
// Storage for one TLB way. Reset starts a sweep that clears
// one set per cycle; init_done rises after tlb_num_sets cycles
// Read data appears two cycles after the read index
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_way_ram
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire tlb_pkg::tlb_set_idx_t raddr,
    input  wire tlb_pkg::tlb_set_idx_t waddr,
    input  wire                   wen,
    input  wire tlb_pkg::tlb_entry_t   wdata,
    output tlb_pkg::tlb_entry_t   rdata,
    output logic                  init_done
);

    tlb_pkg::tlb_entry_t   mem [tlb_pkg::tlb_num_sets];
    tlb_pkg::tlb_entry_t   rd_q;
    tlb_pkg::tlb_set_idx_t init_idx;

    // Sweep counter walks every set once, then parks
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx  <= '0;
            init_done <= 1'b0;
        end
        else if (!init_done)
        begin
            init_idx <= init_idx + 1'b1;
            // Last set is being cleared in this cycle
            if (init_idx == tlb_pkg::tlb_set_idx_t'(tlb_pkg::tlb_num_sets - 1))
            begin
                init_done <= 1'b1;
            end
        end
    end

    // Single write port shared by the sweep and the fill path
    always_ff @(posedge clk)
    begin
        if (!init_done)
        begin
            mem[init_idx] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Two register stages on the read side, as a block RAM with
    // an output register would give
    always_ff @(posedge clk)
    begin
        rd_q  <= mem[raddr];
        rdata <= rd_q;
    end

    // The fill path must hold off until the sweep has finished,
    // otherwise its write would be lost or overwritten
    a_no_write_during_init: assert property (
        @(posedge clk) disable iff (reset)
        wen |-> init_done
    );

endmodule

`default_nettype wire

// ==== rtl/tlb_lookup_pipe.sv ====
// ==========================================================
// Four stage lookup path: decode and read, wait, tag XOR,
// reduce to a per-way hit. One lookup may enter every cycle
// There is no stall; results leave on the fourth edge
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup_pipe
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      lookup_en,
    input  wire tlb_pkg::tlb_va_page_u    lookup_va,
    input  wire tlb_pkg::tlb_entry_t      way_rdata [tlb_pkg::tlb_num_ways],
    output tlb_pkg::tlb_set_idx_t    raddr,
    output tlb_pkg::tlb_way_vec_t    hit_vec,
    output tlb_pkg::tlb_entry_t      stg4_entries [tlb_pkg::tlb_num_ways],
    output tlb_pkg::tlb_va_page_u    stg4_va,
    output logic                     stg4_did_lookup
);

    localparam int last = tlb_pkg::tlb_lookup_stages;

    // Per-stage state that travels with each lookup
    logic                  stg_did [1:last];
    tlb_pkg::tlb_va_page_u stg_va  [1:last];

    // Way entries, registered after they leave the storage
    tlb_pkg::tlb_entry_t stg_entries [3:last][tlb_pkg::tlb_num_ways];

    // First half of the tag compare, one XOR word per way
    tlb_pkg::tlb_tag_t xor_tag [tlb_pkg::tlb_num_ways];

    // ==========================================================
    // Stage 0: decode the page and address every way at once
    // ==========================================================

    assign raddr = lookup_va.f.idx;

    // Only the lookup flag carries a reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 1; s <= last; s++)
            begin
                stg_did[s] <= 1'b0;
            end
        end
        else
        begin
            stg_did[1] <= lookup_en;
            for (int s = 1; s < last; s++)
            begin
                stg_did[s + 1] <= stg_did[s];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stg_va[1] <= lookup_va;
        for (int s = 1; s < last; s++)
        begin
            stg_va[s + 1] <= stg_va[s];
        end
    end

    // ==========================================================
    // Stage 1 only waits for the storage read
    // Stage 2: partial compare, XOR of each stored tag
    // ==========================================================

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < tlb_pkg::tlb_num_ways; w++)
        begin
            xor_tag[w]        <= way_rdata[w].tag ^ stg_va[2].f.tag;
            stg_entries[3][w] <= way_rdata[w];
        end
        stg_entries[4] <= stg_entries[3];
    end

    // ==========================================================
    // Stage 3: a way hits when all XOR bits are zero
    // ==========================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hit_vec <= '0;
        end
        else
        begin
            for (int w = 0; w < tlb_pkg::tlb_num_ways; w++)
            begin
                // Cleared entries have valid low and never match
                hit_vec[w] <= stg_did[3] && stg_entries[3][w].valid && ~(|xor_tag[w]);
            end
        end
    end

    // Final stage state goes straight to the result logic
    assign stg4_entries    = stg_entries[last];
    assign stg4_va         = stg_va[last];
    assign stg4_did_lookup = stg_did[last];

endmodule

`default_nettype wire

// ==== rtl/tlb_hit_select.sv ====
// ==========================================================
// Result logic after the lookup pipeline. Purely combinational
// A page filled twice would hit in two ways; the lowest
// hitting way wins
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_hit_select
(
    input  wire tlb_pkg::tlb_way_vec_t   hit_vec,
    input  wire tlb_pkg::tlb_entry_t     stg4_entries [tlb_pkg::tlb_num_ways],
    input  wire tlb_pkg::tlb_va_page_u   stg4_va,
    input  wire                     stg4_did_lookup,
    output logic                    lookup_valid,
    output logic                    lookup_miss,
    output tlb_pkg::tlb_va_page_u   lookup_miss_va,
    output tlb_pkg::tlb_pa_page_t   lookup_pa
);

    // Hit bits are already qualified by the lookup flag
    assign lookup_valid = |hit_vec;

    // A lookup that found nothing goes back out as a miss
    assign lookup_miss = stg4_did_lookup && !lookup_valid;

    // Missed page is returned so the caller can walk for it
    assign lookup_miss_va = stg4_va;

    // Pick the physical page of the hitting way
    always_comb
    begin
        lookup_pa = '0;
        // Walking downward leaves the lowest hit in place
        for (int w = tlb_pkg::tlb_num_ways - 1; w >= 0; w--)
        begin
            if (hit_vec[w])
            begin
                lookup_pa = stg4_entries[w].pa;
            end
        end
    end

    // Fills never insert a page that is already present, so the
    // compare over all ways finds at most one match
    always_comb
    begin
        a_single_hit: assert #0 ($onehot0(hit_vec));
    end

endmodule

`default_nettype wire

// ==== rtl/tlb_victim_select.sv ====
// ==========================================================
// Round-robin victim choice, one pointer per set. The reply
// comes one cycle after req. Pointers survive an invalidate
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_victim_select
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req,
    input  wire tlb_pkg::tlb_set_idx_t   set_idx,
    output logic                    rsp,
    output tlb_pkg::tlb_way_vec_t   way_vec
);

    // Next way to evict in each set
    tlb_pkg::tlb_way_idx_t ptr [tlb_pkg::tlb_num_sets];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp <= 1'b0;
            for (int s = 0; s < tlb_pkg::tlb_num_sets; s++)
            begin
                ptr[s] <= '0;
            end
        end
        else
        begin
            rsp <= req;
            // Each request consumes the pointer; it wraps after the last way
            if (req)
            begin
                ptr[set_idx] <= ptr[set_idx] + 1'b1;
            end
        end
    end

    // One-hot form of the pointer as it stood at the request
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            way_vec <= tlb_pkg::tlb_way_vec_t'(1) << ptr[set_idx];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tlb_fill_ctrl.sv ====
// ==========================================================
// Fill FSM. Accepts a translation when idle and initialized,
// asks for a victim way, writes the entry, then idles for
// tlb_fill_bubble_cycles. Busy for six cycles per fill
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_fill_ctrl
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     initialized,
    input  wire                     fill_en,
    input  wire tlb_pkg::tlb_va_page_u   fill_va,
    input  wire tlb_pkg::tlb_pa_page_t   fill_pa,
    input  wire                     victim_rsp,
    input  wire tlb_pkg::tlb_way_vec_t   victim_vec,
    output logic                    fill_rdy,
    output logic                    victim_req,
    output tlb_pkg::tlb_set_idx_t   victim_idx,
    output tlb_pkg::tlb_set_idx_t   waddr,
    output tlb_pkg::tlb_entry_t     wdata,
    output tlb_pkg::tlb_way_vec_t   wen
);

    localparam int bubble_last = tlb_pkg::tlb_fill_bubble_cycles - 1;

    tlb_pkg::tlb_fill_state_t state;
    logic [$clog2(tlb_pkg::tlb_fill_bubble_cycles)-1:0] bubble_cnt;

    // Translation being inserted and the way chosen for it
    tlb_pkg::tlb_va_page_u fill_va_q;
    tlb_pkg::tlb_pa_page_t fill_pa_q;
    tlb_pkg::tlb_way_vec_t victim_q;

    // New work only while idle and the storage is swept
    assign fill_rdy = (state == tlb_pkg::fill_idle) && initialized;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= tlb_pkg::fill_idle;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                tlb_pkg::fill_idle:
                begin
                    if (fill_en && fill_rdy)
                    begin
                        state <= tlb_pkg::fill_req_way;
                    end
                end
                // The victim request goes out during this state
                tlb_pkg::fill_req_way: state <= tlb_pkg::fill_recv_way;
                tlb_pkg::fill_recv_way:
                begin
                    if (victim_rsp)
                    begin
                        state <= tlb_pkg::fill_insert;
                    end
                end
                tlb_pkg::fill_insert:
                begin
                    state      <= tlb_pkg::fill_bubble;
                    bubble_cnt <= '0;
                end
                tlb_pkg::fill_bubble:
                begin
                    // Gives the new entry time to settle before the
                    // next fill can be accepted
                    bubble_cnt <= bubble_cnt + 1'b1;
                    if (bubble_cnt == bubble_last)
                    begin
                        state <= tlb_pkg::fill_idle;
                    end
                end
                default: state <= tlb_pkg::fill_idle;
            endcase
        end
    end

    // Payload capture, no reset needed
    always_ff @(posedge clk)
    begin
        if (state == tlb_pkg::fill_idle && fill_en)
        begin
            fill_va_q <= fill_va;
            fill_pa_q <= fill_pa;
        end
        if (victim_rsp)
        begin
            victim_q <= victim_vec;
        end
    end

    assign victim_req = (state == tlb_pkg::fill_req_way);
    assign victim_idx = fill_va_q.f.idx;

    // Write the chosen way of the target set, marked valid
    assign waddr       = fill_va_q.f.idx;
    assign wdata.valid = 1'b1;
    assign wdata.tag   = fill_va_q.f.tag;
    assign wdata.pa    = fill_pa_q;
    assign wen = {tlb_pkg::tlb_num_ways{state == tlb_pkg::fill_insert}} & victim_q;

    // The victim selector must answer with exactly one way, and
    // a write may only happen in the insert cycle
    a_wen_onehot: assert property (
        @(posedge clk) disable iff (reset)
        (wen != '0) |-> (state == tlb_pkg::fill_insert) && $onehot(wen)
    );

endmodule

`default_nettype wire

// ==== rtl/tlb_top.sv ====
// ==========================================================
// TLB top level. A one-cycle inval restarts the storage sweep
// and drops every entry; lookup_en and fill_en must wait for
// lookup_rdy and fill_rdy. Results cannot be stalled
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tlb_top
(
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     lookup_en,
    input  wire tlb_pkg::tlb_va_page_u   lookup_va,
    input  wire                     fill_en,
    input  wire tlb_pkg::tlb_va_page_u   fill_va,
    input  wire tlb_pkg::tlb_pa_page_t   fill_pa,
    input  wire                     inval,
    output logic                    lookup_rdy,
    output logic                    lookup_valid,
    output logic                    lookup_miss,
    output tlb_pkg::tlb_va_page_u   lookup_miss_va,
    output tlb_pkg::tlb_pa_page_t   lookup_pa,
    output logic                    fill_rdy
);

    // Storage side
    tlb_pkg::tlb_entry_t   way_rdata [tlb_pkg::tlb_num_ways];
    logic                  way_init_done [tlb_pkg::tlb_num_ways];
    tlb_pkg::tlb_set_idx_t raddr;
    tlb_pkg::tlb_set_idx_t waddr;
    tlb_pkg::tlb_entry_t   wdata;
    tlb_pkg::tlb_way_vec_t wen;
    logic                  initialized;
    logic                  reset_tlb;

    // Lookup result path
    tlb_pkg::tlb_way_vec_t hit_vec;
    tlb_pkg::tlb_entry_t   stg4_entries [tlb_pkg::tlb_num_ways];
    tlb_pkg::tlb_va_page_u stg4_va;
    logic                  stg4_did_lookup;

    // Victim request path
    logic                  victim_req;
    logic                  victim_rsp;
    tlb_pkg::tlb_set_idx_t victim_idx;
    tlb_pkg::tlb_way_vec_t victim_vec;

    // Invalidate reuses the sweep that follows reset
    assign reset_tlb = reset || inval;

    // All ways sweep in lockstep, so way 0 speaks for all
    assign initialized = way_init_done[0];
    assign lookup_rdy  = initialized;

    // ==========================================================
    // One storage block per way, written separately
    // ==========================================================

    for (genvar w = 0; w < tlb_pkg::tlb_num_ways; w++)
    begin : g_way
        tlb_way_ram u_way_ram
        (
            .clk       (clk),
            .reset     (reset_tlb),
            .raddr     (raddr),
            .waddr     (waddr),
            .wen       (wen[w]),
            .wdata     (wdata),
            .rdata     (way_rdata[w]),
            .init_done (way_init_done[w])
        );
    end

    tlb_lookup_pipe u_lookup_pipe
    (
        .clk, .reset, .lookup_en, .lookup_va, .way_rdata, .raddr,
        .hit_vec, .stg4_entries, .stg4_va, .stg4_did_lookup
    );

    tlb_hit_select u_hit_select
    (
        .hit_vec, .stg4_entries, .stg4_va, .stg4_did_lookup,
        .lookup_valid, .lookup_miss, .lookup_miss_va, .lookup_pa
    );

    tlb_fill_ctrl u_fill_ctrl
    (
        .clk, .reset, .initialized, .fill_en, .fill_va, .fill_pa,
        .victim_rsp, .victim_vec, .fill_rdy, .victim_req, .victim_idx,
        .waddr, .wdata, .wen
    );

    tlb_victim_select u_victim_select
    (
        .clk     (clk),
        .reset   (reset),
        .req     (victim_req),
        .set_idx (victim_idx),
        .rsp     (victim_rsp),
        .way_vec (victim_vec)
    );

endmodule

`default_nettype wire

// ==== bench/tb_tlb.sv ====
// ==========================================================
// TLB testbench with a reference model of pages and per-set
// round-robin ways. Stimulus never overlaps an inval with a
// fill or a lookup in flight. Concurrent assertions do the checks
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_tlb;

    localparam int unsigned tb_seed = 32'hb060_1e58;
    localparam int wait_limit     = 200;
    localparam int reset_cycles   = 10;
    localparam int result_latency = 4;
    localparam int fill_busy      = 6;

    typedef logic [tlb_pkg::tlb_va_page_bits-1:0] vpage_t;
    typedef tlb_pkg::tlb_pa_page_t ppage_t;

    logic                  clk;
    logic                  reset;
    logic                  lookup_en;
    tlb_pkg::tlb_va_page_u lookup_va;
    logic                  fill_en;
    tlb_pkg::tlb_va_page_u fill_va;
    ppage_t                fill_pa;
    logic                  inval;
    logic                  lookup_rdy;
    logic                  lookup_valid;
    logic                  lookup_miss;
    tlb_pkg::tlb_va_page_u lookup_miss_va;
    ppage_t                lookup_pa;
    logic                  fill_rdy;

    // Reference model: present pages, and what each way of each set holds
    ppage_t      ref_map  [vpage_t];
    vpage_t      way_page [tlb_pkg::tlb_num_sets][tlb_pkg::tlb_num_ways];
    bit          way_used [tlb_pkg::tlb_num_sets][tlb_pkg::tlb_num_ways];
    int unsigned rr_ptr   [tlb_pkg::tlb_num_sets];

    // Lookups in flight, stamped with the cycle they were issued
    int unsigned pend_cycle [$];
    bit          pend_hit   [$];
    ppage_t      pend_pa    [$];
    vpage_t      pend_va    [$];
    int unsigned cycle_cnt;

    // Expectation for the result sampled at the next edge
    logic   exp_due;
    logic   exp_hit;
    ppage_t exp_pa;
    vpage_t exp_va;

    tlb_top i_tlb_top
    (
        .clk            (clk),
        .reset          (reset),
        .lookup_en      (lookup_en),
        .lookup_va      (lookup_va),
        .fill_en        (fill_en),
        .fill_va        (fill_va),
        .fill_pa        (fill_pa),
        .inval          (inval),
        .lookup_rdy     (lookup_rdy),
        .lookup_valid   (lookup_valid),
        .lookup_miss    (lookup_miss),
        .lookup_miss_va (lookup_miss_va),
        .lookup_pa      (lookup_pa),
        .fill_rdy       (fill_rdy)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================

    // Invalidate empties every way but leaves the pointers alone
    function automatic void clear_entries();
        ref_map.delete();
        for (int s = 0; s < tlb_pkg::tlb_num_sets; s++)
        begin
            for (int w = 0; w < tlb_pkg::tlb_num_ways; w++)
            begin
                way_used[s][w] = 1'b0;
            end
        end
    endfunction

    function automatic void reset_model();
        clear_entries();
        for (int s = 0; s < tlb_pkg::tlb_num_sets; s++)
        begin
            rr_ptr[s] = 0;
        end
        pend_cycle.delete();
        pend_hit.delete();
        pend_pa.delete();
        pend_va.delete();
    endfunction

    // The set comes from the low page bits, the victim from the set pointer
    function automatic void record_fill(input vpage_t page, input ppage_t pa);
        int unsigned set;
        int unsigned way;
        set = page[tlb_pkg::tlb_idx_bits-1:0];
        way = rr_ptr[set];
        if (way_used[set][way])
        begin
            ref_map.delete(way_page[set][way]);
        end
        way_page[set][way] = page;
        way_used[set][way] = 1'b1;
        ref_map[page]      = pa;
        rr_ptr[set]        = (way + 1) % tlb_pkg::tlb_num_ways;
    endfunction

    always @(posedge clk)
    begin
        if (reset)
        begin
            reset_model();
            cycle_cnt <= 0;
            exp_due   <= 1'b0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 1;
            if (inval)
            begin
                clear_entries();
            end
            if (fill_en && fill_rdy)
            begin
                record_fill(fill_va.page, fill_pa);
            end
            // Oldest lookup comes due one edge before its result is sampled
            if (pend_cycle.size() != 0 && pend_cycle[0] + result_latency - 1 == cycle_cnt)
            begin
                exp_due <= 1'b1;
                exp_hit <= pend_hit.pop_front();
                exp_pa  <= pend_pa.pop_front();
                exp_va  <= pend_va.pop_front();
                void'(pend_cycle.pop_front());
            end
            else
            begin
                exp_due <= 1'b0;
            end
            if (lookup_en)
            begin
                pend_cycle.push_back(cycle_cnt);
                pend_hit.push_back(ref_map.exists(lookup_va.page));
                pend_pa.push_back(ref_map.exists(lookup_va.page) ? ref_map[lookup_va.page] : '0);
                pend_va.push_back(lookup_va.page);
            end
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    a_quiet_in_reset: assert property (@(posedge clk)
        reset ##1 reset |-> !lookup_rdy && !fill_rdy && !lookup_valid && !lookup_miss)
        else fail_run("Ready or result outputs were active during reset");

    a_lookup_when_ready: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> lookup_rdy)
        else fail_run("A lookup was issued while lookup_rdy was low");

    a_one_result: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> ##result_latency (lookup_valid ^ lookup_miss))
        else fail_run("No single valid or miss result four cycles after a lookup");

    a_no_stray_result: assert property (@(posedge clk) disable iff (reset)
        (lookup_valid || lookup_miss) |-> exp_due)
        else fail_run("A result appeared with no lookup in flight");

    a_valid_value: assert property (@(posedge clk) disable iff (reset)
        exp_due |-> lookup_valid == exp_hit)
        else fail_run($sformatf("[ERROR] lookup_valid got %h expected %h",
            $sampled(lookup_valid), $sampled(exp_hit)));

    a_pa_value: assert property (@(posedge clk) disable iff (reset)
        exp_due && exp_hit |-> lookup_pa == exp_pa)
        else fail_run($sformatf("[ERROR] lookup_pa got %h expected %h",
            $sampled(lookup_pa), $sampled(exp_pa)));

    a_miss_va_value: assert property (@(posedge clk) disable iff (reset)
        exp_due && !exp_hit |-> lookup_miss_va.page == exp_va)
        else fail_run($sformatf("[ERROR] lookup_miss_va got %h expected %h",
            $sampled(lookup_miss_va.page), $sampled(exp_va)));

    // Request, receive, insert and three bubble cycles
    a_fill_busy: assert property (@(posedge clk) disable iff (reset)
        fill_en && fill_rdy |=> !fill_rdy [*fill_busy] ##1 fill_rdy)
        else fail_run("fill_rdy was not low for exactly six cycles after a fill");

    a_inval_drops: assert property (@(posedge clk) disable iff (reset)
        inval |=> !lookup_rdy && !fill_rdy)
        else fail_run("Ready outputs stayed high after an invalidate");

    // ==========================================================
    // Stimulus helpers
    // ==========================================================

    task automatic wait_lookup_rdy();
        int n;
        n = 0;
        @(posedge clk);
        while (!lookup_rdy && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (!lookup_rdy)
        begin
            fail_run("lookup_rdy did not rise before the timeout");
        end
    endtask

    task automatic wait_fill_rdy();
        int n;
        n = 0;
        @(posedge clk);
        while (!fill_rdy && n < wait_limit)
        begin
            @(posedge clk);
            n++;
        end
        if (!fill_rdy)
        begin
            fail_run("fill_rdy did not rise before the timeout");
        end
    endtask

    // Looked at on the falling edge, once the model queue has settled
    task automatic wait_results_drained();
        int n;
        n = 0;
        @(negedge clk);
        while ((pend_cycle.size() != 0 || exp_due) && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (pend_cycle.size() != 0 || exp_due)
        begin
            fail_run("Lookup results did not drain before the timeout");
        end
    endtask

    // Consecutive calls issue lookups on consecutive cycles
    task automatic issue_lookup(input vpage_t page);
        wait_lookup_rdy();
        lookup_en      <= 1'b1;
        lookup_va.page <= page;
    endtask

    task automatic end_lookups();
        @(posedge clk);
        lookup_en <= 1'b0;
        wait_results_drained();
    endtask

    // A poke drives a second fill while the first one is busy
    task automatic do_fill(input vpage_t page, input ppage_t pa, input bit poke,
                           input vpage_t poke_page);
        wait_fill_rdy();
        fill_en      <= 1'b1;
        fill_va.page <= page;
        fill_pa      <= pa;
        @(posedge clk);
        fill_en <= 1'b0;
        if (poke)
        begin
            @(posedge clk);
            fill_en      <= 1'b1;
            fill_va.page <= poke_page;
            fill_pa      <= ~pa;
            @(posedge clk);
            fill_en <= 1'b0;
        end
        wait_fill_rdy();
    endtask

    function automatic vpage_t fresh_page();
        vpage_t page;
        page = vpage_t'($urandom());
        while (ref_map.exists(page))
        begin
            page = vpage_t'($urandom());
        end
        return page;
    endfunction

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial
    begin
        vpage_t                page;
        vpage_t                poke_page;
        vpage_t                filled [$];
        vpage_t                group [$];
        tlb_pkg::tlb_tag_t     tag;
        tlb_pkg::tlb_set_idx_t set;

        void'($urandom(tb_seed));
        clk       = 1'b0;
        reset     = 1'b1;
        lookup_en = 1'b0;
        lookup_va = '0;
        fill_en   = 1'b0;
        fill_va   = '0;
        fill_pa   = '0;
        inval     = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // Empty TLB: back-to-back lookups all miss
        wait_fill_rdy();
        for (int i = 0; i < 8; i++)
        begin
            issue_lookup(vpage_t'($urandom()));
        end
        end_lookups();

        // Single fill with a poke during the busy window
        page      = fresh_page();
        poke_page = fresh_page();
        while (poke_page == page)
        begin
            poke_page = fresh_page();
        end
        do_fill(page, ppage_t'($urandom()), 1'b1, poke_page);
        filled.push_back(page);
        issue_lookup(page);
        issue_lookup(poke_page);
        end_lookups();

        // More random fills, then every filled page back to back
        for (int i = 0; i < 6; i++)
        begin
            page = fresh_page();
            do_fill(page, ppage_t'($urandom()), 1'b0, '0);
            filled.push_back(page);
        end
        foreach (filled[i])
        begin
            issue_lookup(filled[i]);
        end
        end_lookups();

        // Five distinct tags in one set evict the first of them
        set = tlb_pkg::tlb_set_idx_t'($urandom());
        while (group.size() < 5)
        begin
            tag  = tlb_pkg::tlb_tag_t'($urandom());
            page = {tag, set};
            if (!ref_map.exists(page) && !(page inside {group}))
            begin
                group.push_back(page);
            end
        end
        foreach (group[i])
        begin
            do_fill(group[i], ppage_t'($urandom()), 1'b0, '0);
            filled.push_back(group[i]);
        end
        foreach (group[i])
        begin
            issue_lookup(group[i]);
        end
        end_lookups();

        // Invalidate pulse, then every earlier page misses
        @(posedge clk);
        inval <= 1'b1;
        @(posedge clk);
        inval <= 1'b0;
        foreach (filled[i])
        begin
            issue_lookup(filled[i]);
        end
        end_lookups();

        // The TLB still fills normally after the invalidate
        page = fresh_page();
        do_fill(page, ppage_t'($urandom()), 1'b0, '0);
        issue_lookup(page);
        end_lookups();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/tlb_pkg.sv
rtl/tlb_way_ram.sv
rtl/tlb_lookup_pipe.sv
rtl/tlb_hit_select.sv
rtl/tlb_victim_select.sv
rtl/tlb_fill_ctrl.sv
rtl/tlb_top.sv
bench/tb_tlb.sv
